// File: source/zoom_defines.svh
`ifndef ZOOM_DEFINES_SVH
`define ZOOM_DEFINES_SVH

// UART bit period after reset, 50 MHz clock at 115200 baud
`define ZOOM_DEFAULT_BIT_PERIOD 13'd434

`define ZOOM_UART_ADDR 16'hFF00          // Status/data register of the receiver

`define ZOOM_RESET_PC 12'h000            // First fetch address

`endif

// File: source/zoom_pkg.sv
package zoom_pkg;

  typedef enum logic [3:0] {
    LDA = 4'h0,                          // acc <= mem[addr]
    STA = 4'h1,                          // mem[addr] <= acc
    JMP = 4'h2,
    LDI = 4'h3,                          // acc <= imm
    LDU = 4'h4,                          // acc <= UART register
    TXA = 4'h5,                          // Send acc[7:0]
    SPD = 4'h6,                          // Bit period <= acc[12:0]
    WRX = 4'h7,                          // Wait for a received byte
    HLT = 4'hF
  } opcode_e;

  typedef struct packed {
    opcode_e     opcode;
    logic [11:0] addr;
  } addr_form_t;

  typedef struct packed {
    opcode_e     opcode;
    logic [3:0]  spare;                  // Reserved, ignored
    logic [7:0]  imm;
  } imm_form_t;

  // Same word seen two ways; opcode sits in bits 15:12 of both
  typedef union packed {
    addr_form_t addr_form;
    imm_form_t  imm_form;
  } instr_u;

endpackage

// File: source/mem_req_if.sv
`timescale 1ns/100ps

interface mem_req_if;

  logic        request;                  // One-cycle pulse, only when idle
  logic        request_type;             // 1 = write
  logic [15:0] request_address;
  logic [15:0] write_data;
  logic [15:0] read_data;                // Valid with memory_ready
  logic        memory_ready;
  logic        write_complete;

  modport cpu (
    output request, request_type, request_address, write_data,
    input  read_data, memory_ready, write_complete
  );

  modport ctrl (
    input  request, request_type, request_address, write_data,
    output read_data, memory_ready, write_complete
  );

endinterface

// File: source/uart_rx.sv
`timescale 1ns/100ps
`include "zoom_defines.svh"

module uart_rx (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        rx,
  input  logic        set_speed,
  input  logic [12:0] speed,
  output logic        uart_inbound,
  output logic [7:0]  data_received
);

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

  rx_state_e   state;
  logic [1:0]  rx_sync;
  logic        rx_line;
  logic [12:0] bit_period;
  logic [12:0] cnt;
  logic [2:0]  bit_idx;
  logic        half_hit;
  logic        full_hit;
  logic [7:0]  shift;

  assign rx_line  = rx_sync[1];
  assign half_hit = (cnt == (bit_period >> 1));       // Middle of start bit
  assign full_hit = (cnt == bit_period - 13'd1);      // One period on, middle of next bit
  assign data_received = shift;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rx_sync      <= 2'b11;                          // Line idles high
      bit_period   <= `ZOOM_DEFAULT_BIT_PERIOD;
      state        <= RX_IDLE;
      cnt          <= '0;
      bit_idx      <= '0;
      uart_inbound <= 1'b0;
    end else begin
      rx_sync      <= {rx_sync[0], rx};
      uart_inbound <= 1'b0;
      if (set_speed) begin
        bit_period <= speed;
      end
      case (state)
        RX_IDLE: begin
          cnt     <= '0;
          bit_idx <= '0;
          if (!rx_line) begin
            state <= RX_START;                        // Falling edge of start bit
          end
        end
        RX_START: begin
          if (half_hit) begin
            cnt   <= '0;
            state <= rx_line ? RX_IDLE : RX_DATA;     // Glitch returns to idle
          end else begin
            cnt <= cnt + 13'd1;
          end
        end
        RX_DATA: begin
          if (full_hit) begin
            cnt     <= '0;
            bit_idx <= bit_idx + 3'd1;
            if (bit_idx == 3'd7) begin
              state <= RX_STOP;
            end
          end else begin
            cnt <= cnt + 13'd1;
          end
        end
        RX_STOP: begin
          if (full_hit) begin
            uart_inbound <= rx_line;                  // Low stop bit drops the byte
            state        <= RX_IDLE;
          end else begin
            cnt <= cnt + 13'd1;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == RX_DATA && full_hit) begin
      shift <= {rx_line, shift[7:1]};                 // LSB first
    end
  end

  // A frame lasts many bit periods, so two pulses back to back mean a broken FSM
  a_single_pulse: assert property (@(posedge clk) disable iff (!arst_n)
    uart_inbound |=> !uart_inbound);

endmodule

// File: source/uart_tx.sv
`timescale 1ns/100ps

module uart_tx (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        start,
  input  logic [7:0]  data,
  input  logic [12:0] bit_period,
  output logic        tx,
  output logic        busy
);

  logic [8:0]  frame;                    // Data bits then stop bit
  logic [12:0] cnt;
  logic [3:0]  bit_cnt;                  // Bits already on the line

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      tx      <= 1'b1;
      busy    <= 1'b0;
      frame   <= '1;
      cnt     <= '0;
      bit_cnt <= '0;
    end else if (!busy) begin
      if (start) begin
        busy    <= 1'b1;
        tx      <= 1'b0;                 // Start bit
        frame   <= {1'b1, data};
        cnt     <= '0;
        bit_cnt <= '0;
      end
    end else if (cnt == bit_period - 13'd1) begin
      cnt <= '0;
      if (bit_cnt == 4'd9) begin
        busy <= 1'b0;                    // Stop bit done
        tx   <= 1'b1;
      end else begin
        tx      <= frame[0];
        frame   <= {1'b1, frame[8:1]};
        bit_cnt <= bit_cnt + 4'd1;
      end
    end else begin
      cnt <= cnt + 13'd1;
    end
  end

endmodule

// File: source/memory_controller.sv
`timescale 1ns/100ps
`include "zoom_defines.svh"

module memory_controller (
  input  logic       clk,
  input  logic       arst_n,
  mem_req_if.ctrl    mem,
  input  logic       uart_inbound,
  input  logic [7:0] data_received,
  input  logic       lower_byte_in,
  input  logic       upper_byte_in,
  input  logic [7:0] data_input_pins,
  output logic [7:0] data_output_pins,
  output logic [7:0] iovalue,
  output logic       write_enable,
  output logic       register_enable,
  output logic       read_enable,
  output logic       lower_bit,
  output logic       upper_bit
);

  typedef enum logic [3:0] {
    S_IDLE, S_UART, S_ADDR_LO, S_ADDR_HI,
    S_RD_LO, S_RD_LO_REL, S_RD_HI, S_RD_HI_REL,
    S_WR_LO, S_WR_LO_REL, S_WR_HI, S_WR_HI_REL
  } ctrl_state_e;

  ctrl_state_e state;
  logic [1:0]  lower_sync;
  logic [1:0]  upper_sync;
  logic        lower_seen;
  logic        upper_seen;
  logic        uart_hit;
  logic        write_q;
  logic [15:0] addr_q;
  logic [15:0] wdata_q;
  logic [15:0] rdata_q;
  logic [7:0]  uart_byte;
  logic        uart_pending;
  logic        ready_q;
  logic        complete_q;

  assign lower_seen = lower_sync[1];
  assign upper_seen = upper_sync[1];
  assign uart_hit   = !mem.request_type && (mem.request_address == `ZOOM_UART_ADDR);

  assign mem.read_data      = rdata_q;
  assign mem.memory_ready   = ready_q;
  assign mem.write_complete = complete_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state        <= S_IDLE;
      lower_sync   <= '0;
      upper_sync   <= '0;
      write_q      <= 1'b0;
      uart_byte    <= '0;
      uart_pending <= 1'b0;
      ready_q      <= 1'b0;
      complete_q   <= 1'b0;
    end else begin
      lower_sync <= {lower_sync[0], lower_byte_in};
      upper_sync <= {upper_sync[0], upper_byte_in};
      ready_q    <= 1'b0;
      complete_q <= 1'b0;
      if (uart_inbound) begin
        uart_byte    <= data_received;     // Newest byte wins
        uart_pending <= 1'b1;
      end else if (state == S_UART) begin
        uart_pending <= 1'b0;
      end
      case (state)
        S_IDLE: begin
          if (mem.request) begin
            write_q <= mem.request_type;
            state   <= uart_hit ? S_UART : S_ADDR_LO;
          end
        end
        S_UART: begin
          ready_q <= 1'b1;
          state   <= S_IDLE;
        end
        S_ADDR_LO:   state <= S_ADDR_HI;
        S_ADDR_HI:   state <= write_q ? S_WR_LO : S_RD_LO;
        S_RD_LO:     if (lower_seen) state <= S_RD_LO_REL;
        S_RD_LO_REL: if (!lower_seen) state <= S_RD_HI;
        S_RD_HI:     if (upper_seen) state <= S_RD_HI_REL;
        S_RD_HI_REL: begin
          if (!upper_seen) begin
            ready_q <= 1'b1;
            state   <= S_IDLE;
          end
        end
        S_WR_LO:     if (lower_seen) state <= S_WR_LO_REL;
        S_WR_LO_REL: if (!lower_seen) state <= S_WR_HI;
        S_WR_HI:     if (upper_seen) state <= S_WR_HI_REL;
        S_WR_HI_REL: begin
          if (!upper_seen) begin
            complete_q <= 1'b1;
            state      <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_IDLE && mem.request) begin
      addr_q  <= mem.request_address;
      wdata_q <= mem.write_data;
    end
    if (state == S_UART) begin
      rdata_q <= {7'b0, uart_pending, uart_byte};
    end
    if (state == S_RD_LO && lower_seen) begin
      rdata_q[7:0] <= data_input_pins;     // Data settled before the strobe
    end
    if (state == S_RD_HI && upper_seen) begin
      rdata_q[15:8] <= data_input_pins;
    end
  end

  always_comb begin
    data_output_pins = '0;
    iovalue          = '0;
    write_enable     = 1'b0;
    register_enable  = 1'b0;
    read_enable      = 1'b0;
    lower_bit        = 1'b0;
    upper_bit        = 1'b0;
    case (state)
      S_ADDR_LO: begin
        data_output_pins = addr_q[7:0];
        iovalue          = '1;
        register_enable  = 1'b1;
        lower_bit        = 1'b1;
      end
      S_ADDR_HI: begin
        data_output_pins = addr_q[15:8];
        iovalue          = '1;
        register_enable  = 1'b1;
        upper_bit        = 1'b1;
      end
      S_RD_LO, S_RD_LO_REL, S_RD_HI, S_RD_HI_REL: begin
        read_enable = 1'b1;                // Pins released to the memory
      end
      S_WR_LO, S_WR_LO_REL: begin
        data_output_pins = wdata_q[7:0];
        iovalue          = '1;
        write_enable     = 1'b1;
        lower_bit        = 1'b1;
      end
      S_WR_HI, S_WR_HI_REL: begin
        data_output_pins = wdata_q[15:8];
        iovalue          = '1;
        write_enable     = 1'b1;
        upper_bit        = 1'b1;
      end
      default: ;
    endcase
  end

  // Pin direction follows the request type latched at the handshake
  a_no_rd_wr_overlap: assert property (@(posedge clk) disable iff (!arst_n)
    !(read_enable && write_q) && !(write_enable && !write_q));

  a_iovalue_whole_bus: assert property (@(posedge clk) disable iff (!arst_n)
    iovalue inside {8'h00, 8'hFF});

endmodule

// File: source/zoom_cpu.sv
`timescale 1ns/100ps
`include "zoom_defines.svh"

module zoom_cpu (
  input  logic        clk,
  input  logic        arst_n,
  mem_req_if.cpu      mem,
  input  logic        uart_inbound,
  output logic        tx,
  output logic        set_rx_speed,
  output logic [12:0] rx_speed
);

  typedef enum logic [2:0] {
    S_FETCH, S_FETCH_WAIT, S_EXEC, S_MEM_WAIT, S_TX_WAIT, S_RX_WAIT, S_HALT
  } cpu_state_e;

  cpu_state_e        state;
  logic [11:0]       pc;
  logic [15:0]       acc;
  logic [12:0]       bit_period;
  zoom_pkg::instr_u  ir;
  zoom_pkg::opcode_e op;
  logic              tx_start;
  logic              tx_busy;

  assign op       = ir.addr_form.opcode;
  assign rx_speed = bit_period;

  always_comb begin
    mem.request         = 1'b0;
    mem.request_type    = 1'b0;
    mem.request_address = {4'h0, pc};
    mem.write_data      = acc;
    tx_start            = 1'b0;
    case (state)
      S_FETCH: mem.request = 1'b1;
      S_EXEC: begin
        case (op)
          zoom_pkg::LDA: begin
            mem.request         = 1'b1;
            mem.request_address = {4'h0, ir.addr_form.addr};
          end
          zoom_pkg::STA: begin
            mem.request         = 1'b1;
            mem.request_type    = 1'b1;
            mem.request_address = {4'h0, ir.addr_form.addr};
          end
          zoom_pkg::LDU: begin
            mem.request         = 1'b1;
            mem.request_address = `ZOOM_UART_ADDR;
          end
          zoom_pkg::TXA: tx_start = 1'b1;
          default: ;
        endcase
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state        <= S_FETCH;
      pc           <= `ZOOM_RESET_PC;
      acc          <= '0;
      bit_period   <= `ZOOM_DEFAULT_BIT_PERIOD;
      set_rx_speed <= 1'b0;
    end else begin
      set_rx_speed <= 1'b0;
      case (state)
        S_FETCH: state <= S_FETCH_WAIT;
        S_FETCH_WAIT: begin
          if (mem.memory_ready) begin
            pc    <= pc + 12'd1;
            state <= S_EXEC;
          end
        end
        S_EXEC: begin
          case (op)
            zoom_pkg::LDA, zoom_pkg::STA, zoom_pkg::LDU: state <= S_MEM_WAIT;
            zoom_pkg::JMP: begin
              pc    <= ir.addr_form.addr;
              state <= S_FETCH;
            end
            zoom_pkg::LDI: begin
              acc   <= {8'h00, ir.imm_form.imm};
              state <= S_FETCH;
            end
            zoom_pkg::TXA: state <= S_TX_WAIT;
            zoom_pkg::SPD: begin
              bit_period   <= acc[12:0];   // Shared by both UART directions
              set_rx_speed <= 1'b1;
              state        <= S_FETCH;
            end
            zoom_pkg::WRX: state <= S_RX_WAIT;
            zoom_pkg::HLT: state <= S_HALT;
            default: state <= S_FETCH;     // Unused opcodes act as NOP
          endcase
        end
        S_MEM_WAIT: begin
          if (mem.memory_ready) begin
            acc   <= mem.read_data;
            state <= S_FETCH;
          end else if (mem.write_complete) begin
            state <= S_FETCH;
          end
        end
        S_TX_WAIT: if (!tx_busy) state <= S_FETCH;   // Busy is up from the cycle after start
        S_RX_WAIT: if (uart_inbound) state <= S_FETCH;
        S_HALT: state <= S_HALT;                    // Only reset leaves
        default: state <= S_FETCH;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_FETCH_WAIT && mem.memory_ready) begin
      ir <= mem.read_data;
    end
  end

  uart_tx transmitter (
    .clk        (clk),
    .arst_n     (arst_n),
    .start      (tx_start),
    .data       (acc[7:0]),
    .bit_period (bit_period),
    .tx         (tx),
    .busy       (tx_busy)
  );

  // Controller takes one transaction at a time
  a_one_open_request: assert property (@(posedge clk) disable iff (!arst_n)
    mem.request |=> (!mem.request until_with (mem.memory_ready || mem.write_complete)));

endmodule

// File: source/tt_um_zoom_zoom.sv
`timescale 1ns/100ps

module tt_um_zoom_zoom (
  input  logic [7:0] ui_in,
  output logic [7:0] uo_out,
  input  logic [7:0] uio_in,
  output logic [7:0] uio_out,
  output logic [7:0] uio_oe,              // 1 drives the pin
  input  logic       ena,
  input  logic       clk,
  input  logic       arst_n
);

  mem_req_if mem_bus ();

  logic        lower_byte_in;
  logic        upper_byte_in;
  logic        rx;
  logic        tx;
  logic        write_enable;
  logic        register_enable;
  logic        read_enable;
  logic        lower_bit;
  logic        upper_bit;
  logic        uart_inbound;
  logic [7:0]  data_received;
  logic        set_rx_speed;
  logic [12:0] rx_speed;
  logic        unused;

  assign lower_byte_in = ui_in[0];        // Memory strobes
  assign upper_byte_in = ui_in[1];
  assign rx            = ui_in[2];

  assign uo_out = {2'b00, upper_bit, tx, lower_bit, read_enable, register_enable, write_enable};

  zoom_cpu cpu (
    .clk          (clk),
    .arst_n       (arst_n),
    .mem          (mem_bus.cpu),
    .uart_inbound (uart_inbound),
    .tx           (tx),
    .set_rx_speed (set_rx_speed),
    .rx_speed     (rx_speed)
  );

  memory_controller memory_controller (
    .clk              (clk),
    .arst_n           (arst_n),
    .mem              (mem_bus.ctrl),
    .uart_inbound     (uart_inbound),
    .data_received    (data_received),
    .lower_byte_in    (lower_byte_in),
    .upper_byte_in    (upper_byte_in),
    .data_input_pins  (uio_in),
    .data_output_pins (uio_out),
    .iovalue          (uio_oe),
    .write_enable     (write_enable),
    .register_enable  (register_enable),
    .read_enable      (read_enable),
    .lower_bit        (lower_bit),
    .upper_bit        (upper_bit)
  );

  uart_rx uart_receiver (
    .clk           (clk),
    .arst_n        (arst_n),
    .rx            (rx),
    .set_speed     (set_rx_speed),
    .speed         (rx_speed),
    .uart_inbound  (uart_inbound),
    .data_received (data_received)
  );

  assign unused = &{ena, ui_in[7:3], 1'b0};  // Spare inputs

endmodule

// File: testbench/tb_zoom.sv
`timescale 1ns/100ps
`include "zoom_defines.svh"

module tb_zoom;

  localparam int uart_bit     = 16;             // Cycles per bit once SPD has run
  localparam int quiet_cycles = 200;            // Halted CPU must stay off the pins
  localparam int writes_at    = 'h1000;         // Expected writes as count then address/data
  localparam int sends_at     = 'h1100;         // Bytes for rx as count then trigger/byte
  localparam int txs_at       = 'h1200;         // Expected bytes on tx
  localparam int reads_at     = 'h1300;         // Expected pin read addresses

  logic        clk;
  logic        arst_n;
  logic        ena;
  logic [7:0]  uio_in;
  logic        lower_strobe;
  logic        upper_strobe;
  logic        rx_line;
  wire  [7:0]  ui_in;
  wire  [7:0]  uo_out;
  wire  [7:0]  uio_out;
  wire  [7:0]  uio_oe;

  logic [15:0] vectors [0:'h13FF];
  logic [15:0] lfsr = 16'd49932;
  logic [15:0] addr;
  logic        lo_phase_seen;
  int          errors = 0;
  int          checks = 0;
  int          n_reads = 0;
  int          n_writes = 0;
  int          n_tx = 0;
  int          limit = 0;
  int          cycles = 0;

  wire write_enable    = uo_out[0];
  wire register_enable = uo_out[1];
  wire read_enable     = uo_out[2];
  wire lower_bit       = uo_out[3];
  wire tx              = uo_out[4];
  wire upper_bit       = uo_out[5];

  assign ui_in = {5'b00000, rx_line, upper_strobe, lower_strobe};

  tt_um_zoom_zoom dut (
    .ui_in   (ui_in),
    .uo_out  (uo_out),
    .uio_in  (uio_in),
    .uio_out (uio_out),
    .uio_oe  (uio_oe),
    .ena     (ena),
    .clk     (clk),
    .arst_n  (arst_n)
  );

  task automatic next_cycle();
    @(posedge clk);
    #2;                                         // Outputs settled and inputs change here
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("MISMATCH %0t %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("ERROR at %0t: %s", $time, what);
  endtask

  // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
  function automatic int lfsr_draw(input int nbits);
    logic fb;
    int   value;
    int   i;
    value = 0;
    for (i = 0; i < nbits; i++) begin
      fb    = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr  = {lfsr[14:0], fb};
      value = (value << 1) | fb;
    end
    return value;
  endfunction

  // Memory answers after a random wait and holds its strobe 3 to 6 cycles
  task automatic strobe_ack(input logic upper);
    int wait_cycles;
    int hold_cycles;
    wait_cycles = lfsr_draw(3);
    hold_cycles = lfsr_draw(2);
    repeat (wait_cycles) next_cycle();
    if (upper) begin
      upper_strobe = 1'b1;
    end else begin
      lower_strobe = 1'b1;
    end
    repeat (hold_cycles + 3) next_cycle();
    lower_strobe = 1'b0;
    upper_strobe = 1'b0;
  endtask

  task automatic serve_read();
    logic [15:0] word;
    word = vectors[addr[11:0]];
    check_value("uio_oe", 8'h00, uio_oe);
    if (addr == `ZOOM_UART_ADDR) begin
      report_failure("UART register read went out to the pins");
    end
    if (n_reads == 0) begin
      check_value("reset_pc", {4'h0, `ZOOM_RESET_PC}, addr);
    end
    if (n_reads < vectors[reads_at]) begin
      check_value("read_address", vectors[reads_at + 1 + n_reads], addr);
    end else begin
      report_failure($sformatf("unexpected pin read at address %h", addr));
    end
    uio_in = word[7:0];
    strobe_ack(1'b0);
    uio_in = word[15:8];                        // High byte goes up with the second strobe
    strobe_ack(1'b1);
    while (read_enable) next_cycle();
    n_reads++;
  endtask

  task automatic take_write();
    logic [15:0] data;
    data[7:0] = uio_out;
    check_value("uio_oe", 8'hFF, uio_oe);
    check_value("lower_bit", 1'b1, lower_bit);
    strobe_ack(1'b0);
    while (!(write_enable && upper_bit)) next_cycle();
    data[15:8] = uio_out;
    strobe_ack(1'b1);
    while (write_enable) next_cycle();
    if (n_writes < vectors[writes_at]) begin
      check_value("write_address", vectors[writes_at + 1 + 2 * n_writes], addr);
      check_value("write_data", vectors[writes_at + 2 + 2 * n_writes], data);
    end else begin
      report_failure($sformatf("unexpected write of %h to address %h", data, addr));
    end
    vectors[addr[11:0]] = data;
    n_writes++;
  endtask

  task automatic send_byte(input logic [7:0] value);
    int i;
    rx_line = 1'b0;                             // Start bit
    repeat (uart_bit) next_cycle();
    for (i = 0; i < 8; i++) begin
      rx_line = value[i];
      repeat (uart_bit) next_cycle();
    end
    rx_line = 1'b1;
    repeat (uart_bit) next_cycle();
  endtask

  initial begin : clock_gen
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  initial begin : memory_model
    lo_phase_seen = 1'b0;
    wait (arst_n === 1'b1);
    forever begin
      next_cycle();
      if (register_enable && lower_bit) begin
        addr[7:0]     = uio_out;
        lo_phase_seen = 1'b1;
        check_value("uio_oe", 8'hFF, uio_oe);
      end else if (register_enable && upper_bit) begin
        addr[15:8] = uio_out;
        check_value("address_order", 1'b1, lo_phase_seen);
        lo_phase_seen = 1'b0;
      end else if (read_enable) begin
        serve_read();
      end else if (write_enable) begin
        take_write();
      end
    end
  end

  initial begin : uart_monitor
    logic [7:0] value;
    int         i;
    wait (arst_n === 1'b1);
    forever begin
      next_cycle();
      if (!tx) begin
        repeat (uart_bit / 2) next_cycle();     // Middle of the start bit
        check_value("tx_start_bit", 1'b0, tx);
        for (i = 0; i < 8; i++) begin
          repeat (uart_bit) next_cycle();
          value[i] = tx;
        end
        repeat (uart_bit) next_cycle();
        check_value("tx_stop_bit", 1'b1, tx);
        if (n_tx < vectors[txs_at]) begin
          check_value("tx_byte", vectors[txs_at + 1 + n_tx], value);
        end else begin
          report_failure($sformatf("unexpected byte %h on tx", value));
        end
        n_tx++;
      end
    end
  end

  initial begin : uart_driver
    int k;
    wait (arst_n === 1'b1);
    for (k = 0; k < vectors[sends_at]; k++) begin
      while (n_reads < vectors[sends_at + 1 + 2 * k]) next_cycle();  // CPU sits in WRX
      repeat (4) next_cycle();
      send_byte(vectors[sends_at + 2 + 2 * k][7:0]);
    end
  end

  initial begin : watchdog
    wait (limit > 0);
    while (cycles <= limit) begin
      next_cycle();
      cycles++;
    end
    $display("Timeout after %0d cycles, the program never finished its transfers", cycles);
    $display("Errors found");
    $finish;
  end

  initial begin : main
    int   i;
    logic first_phase;
    arst_n       = 1'b0;
    ena          = 1'b1;
    uio_in       = 8'h00;
    lower_strobe = 1'b0;
    upper_strobe = 1'b0;
    rx_line      = 1'b1;
    for (i = 0; i < 4096; i++) begin
      vectors[i] = 16'hF000 | i[11:0];          // Unprogrammed words decode as HLT
    end
    $readmemh("testbench/zoom_vectors.txt", vectors);
    limit = 4 * (vectors[txs_at] + vectors[sends_at]) * 10 * uart_bit + 20000;

    repeat (16) begin
      next_cycle();
      check_value("uo_out", 8'h10, uo_out);     // Only tx high
      check_value("uio_oe", 8'h00, uio_oe);
    end
    arst_n = 1'b1;
    #1;
    check_value("uo_out", 8'h10, uo_out);
    check_value("uio_oe", 8'h00, uio_oe);

    first_phase = 1'b0;
    for (i = 0; i < 4 && !first_phase; i++) begin
      next_cycle();
      first_phase = register_enable;
    end
    if (!first_phase) begin
      report_failure("no address phase within 4 cycles of reset release");
    end

    while (n_reads < vectors[reads_at] || n_writes < vectors[writes_at] ||
           n_tx < vectors[txs_at]) begin
      next_cycle();
    end
    repeat (quiet_cycles) next_cycle();

    $display("Summary: %0d checks, %0d errors, %0d reads, %0d writes, %0d tx bytes",
             checks, errors, n_reads, n_writes, n_tx);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: testbench/zoom_vectors.txt
// One 16-bit hex word per entry. 0000-0FFF memory image, 1000 writes (count, address/data pairs)
// 1100 rx bytes (count, pin reads to wait for/byte), 1200 tx bytes (count, bytes), 1300 pin reads
@0000
3010  // LDI 10
6000  // SPD, bit period 16
0100  // LDA 100
1200  // STA 200
3041  // LDI 41
1201  // STA 201
5000  // TXA
2009  // JMP 9
F000  // HLT, skipped
0101  // LDA 101
5000  // TXA
7000  // WRX
4000  // LDU, pending flag set
5000  // TXA, echo
1202  // STA 202
4000  // LDU, pending flag clear
1203  // STA 203
F000  // HLT
@0100
BEEF 1234
@1000
0004 0200 BEEF 0201 0041 0202 01A5 0203 00A5
@1100
0001 000D 00A5
@1200
0003 0041 0034 00A5
@1300
0013 0000 0001 0002 0100 0003 0004 0005 0006 0007 0009
0101 000A 000B 000C 000D 000E 000F 0010 0011

// File: build.f
+incdir+source
source/zoom_pkg.sv
source/mem_req_if.sv
source/uart_rx.sv
source/uart_tx.sv
source/memory_controller.sv
source/zoom_cpu.sv
source/tt_um_zoom_zoom.sv
testbench/tb_zoom.sv

// File: Bender.yml
package:
  name: zoom_zoom

sources:
  - include_dirs:
      - source
    files:
      - source/zoom_pkg.sv
      - source/mem_req_if.sv
      - source/uart_rx.sv
      - source/uart_tx.sv
      - source/memory_controller.sv
      - source/zoom_cpu.sv
      - source/tt_um_zoom_zoom.sv
  - target: test
    include_dirs:
      - source
    files:
      - testbench/tb_zoom.sv
